// File: src/gba_io_pkg.sv
// shared types and register map of the I/O block
// bus addresses are byte addresses; every region is word aligned
// irq_src_t and keys_t are laid out so that bit 0 is the lowest register bit
package gba_io_pkg;

    typedef logic [27:0] io_adr_t;
    typedef logic [3:0]  io_be_t;
    typedef logic [15:0] io_half_t;

    typedef enum logic [1:0] {
        ACC_BYTE    = 2'd0,
        ACC_HALF    = 2'd1,
        ACC_WORD    = 2'd2,
        ACC_INVALID = 2'd3
    } io_acc_e;

    typedef struct packed {
        io_half_t hi;
        io_half_t lo;
    } io_halves_t;

    // one bus word, either as byte lanes or as a register pair
    typedef union packed {
        logic [31:0] raw;
        io_halves_t  halves;
    } io_word_u;

    typedef struct packed {
        logic     valid;
        logic     we;
        logic [1:0] idx;   // word index inside the region
        io_be_t   be;
        io_word_u wdata;
    } io_req_t;

    // IF/IE bit order, vblank is bit 0
    typedef struct packed {
        logic       gamepak;
        logic       keypad;
        logic [3:0] dma;
        logic       serial;
        logic [3:0] timer;
        logic       vcount;
        logic       hblank;
        logic       vblank;
    } irq_src_t;

    // 1 while pressed, a is bit 0
    typedef struct packed {
        logic l;
        logic r;
        logic down;
        logic up;
        logic left;
        logic right;
        logic start;
        logic select;
        logic b;
        logic a;
    } keys_t;

    typedef struct packed {
        logic [7:0] unused_hi;
        logic       start;
        logic       irq_en;
        logic [2:0] unused_lo;
        logic       count_up;
        logic [1:0] prescale;
    } tmr_ctrl_t;

    localparam io_adr_t TIMER_BASE = 28'h000_0100; // four words
    localparam io_adr_t KEY_BASE   = 28'h000_0130; // one word
    localparam io_adr_t INTR_BASE  = 28'h000_0200; // four words

    localparam int unsigned PRESC_DIV [4] = '{1, 64, 256, 1024};

    // byte-lane merge of one halfword register
    function automatic io_half_t merge_half(io_half_t cur, io_half_t nxt, logic [1:0] be);
        io_half_t res;
        res = cur;
        if (be[0])
            res[7:0] = nxt[7:0];
        if (be[1])
            res[15:8] = nxt[15:8];
        return res;
    endfunction

endpackage

// File: src/gba_timer_channel.sv
// one timer channel; overflow is combinational so cascades ripple in one cycle
// irq is a registered one-cycle pulse
module gba_timer_channel (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic                  wr_reload,
    input  logic                  wr_ctrl,
    input  gba_io_pkg::io_half_t  wdata_half,
    input  logic [1:0]            be_half,
    input  logic [3:0]            div_tick,
    input  logic                  cascade_in,
    output gba_io_pkg::io_half_t  count,
    output gba_io_pkg::tmr_ctrl_t ctrl,
    output logic                  overflow,
    output logic                  irq
);

    gba_io_pkg::io_half_t  reload_q;
    gba_io_pkg::io_half_t  count_q;
    gba_io_pkg::tmr_ctrl_t ctrl_q;
    gba_io_pkg::tmr_ctrl_t ctrl_new;
    logic                  ctrl_we;
    logic                  start_load;
    logic                  step;

    // control fields all sit in the low byte
    always_comb begin
        ctrl_new           = wdata_half;
        ctrl_new.unused_hi = '0;
        ctrl_new.unused_lo = '0;
    end

    assign ctrl_we    = wr_ctrl & be_half[0];
    assign start_load = ctrl_we & ctrl_new.start & ~ctrl_q.start;  // start 0 -> 1

    assign step = ctrl_q.start &
                  (ctrl_q.count_up ? cascade_in : div_tick[ctrl_q.prescale]);
    assign overflow = step & (count_q == 16'hFFFF);

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            reload_q <= '0;
            ctrl_q   <= '0;
            count_q  <= '0;
            irq      <= 1'b0;
        end else begin
            if (wr_reload)
                reload_q <= gba_io_pkg::merge_half(reload_q, wdata_half, be_half);
            if (ctrl_we)
                ctrl_q <= ctrl_new;

            if (start_load)
                count_q <= reload_q;
            else if (overflow)
                count_q <= reload_q;   // wrap reloads in the same edge
            else if (step)
                count_q <= count_q + 16'd1;

            irq <= overflow & ctrl_q.irq_en;
        end
    end

    assign count = count_q;
    assign ctrl  = ctrl_q;

endmodule

// File: src/gba_timers.sv
// four 16-bit timers sharing one free-running prescaler
// word n: counter (lo, reload on write) and control (hi)
// control writes land one cycle after the strobe, so a word write that
// starts a timer loads the reload value written with it
module gba_timers (
    input  logic                 clk16,
    input  logic                 resetn,
    input  gba_io_pkg::io_req_t  req,
    output gba_io_pkg::io_word_u rdata,
    output logic [3:0]           timer_irq
);

    logic [9:0]               pre_cnt;
    logic [3:0]               div_tick;
    logic [3:0]               ovf;
    logic [3:0]               casc;
    logic [3:0]               wr_reload;
    logic [3:0]               ctrl_wr_q;
    gba_io_pkg::io_half_t     ctrl_hi_q;
    logic [1:0]               ctrl_be_q;
    gba_io_pkg::io_half_t     wdata_half;
    logic [1:0]               be_half;
    gba_io_pkg::io_half_t     cnt [4];
    gba_io_pkg::tmr_ctrl_t    ctl [4];

    always_ff @(posedge clk16) begin
        if (!resetn)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 10'd1;
    end

    // staged control half
    always_ff @(posedge clk16) begin
        ctrl_hi_q <= req.wdata.halves.hi;
        ctrl_be_q <= req.be[3:2];
    end

    assign casc       = {ovf[2:0], 1'b0};  // timer 0 has nothing to cascade from
    assign wdata_half = |ctrl_wr_q ? ctrl_hi_q : req.wdata.halves.lo;
    assign be_half    = |ctrl_wr_q ? ctrl_be_q : req.be[1:0];

    for (genvar i = 0; i < 4; i++) begin : g_chan
        localparam logic [9:0] DIV_MASK = 10'(gba_io_pkg::PRESC_DIV[i] - 1);

        assign div_tick[i]  = (pre_cnt & DIV_MASK) == DIV_MASK;
        assign wr_reload[i] = req.valid & req.we & (req.idx == 2'(i)) & |req.be[1:0];

        always_ff @(posedge clk16) begin
            if (!resetn)
                ctrl_wr_q[i] <= 1'b0;
            else
                ctrl_wr_q[i] <= req.valid & req.we & (req.idx == 2'(i)) & |req.be[3:2];
        end

        gba_timer_channel u_chan (
            .clk16      (clk16),
            .resetn     (resetn),
            .wr_reload  (wr_reload[i]),
            .wr_ctrl    (ctrl_wr_q[i]),
            .wdata_half (wdata_half),
            .be_half    (be_half),
            .div_tick   (div_tick),
            .cascade_in (casc[i]),
            .count      (cnt[i]),
            .ctrl       (ctl[i]),
            .overflow   (ovf[i]),
            .irq        (timer_irq[i])
        );
    end

    always_comb begin
        rdata.halves.lo = cnt[req.idx];
        rdata.halves.hi = ctl[req.idx];
    end

endmodule

// File: src/gba_io_bus.sv
// register-bus front end, one access outstanding at a time
// done and read data come back exactly one cycle after the ena strobe
// unmapped addresses complete normally and read as 0
module gba_io_bus (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic                  bus_ena,
    input  logic                  bus_rnw,
    input  gba_io_pkg::io_adr_t   bus_adr,
    input  gba_io_pkg::io_acc_e   bus_acc,
    input  gba_io_pkg::io_word_u  bus_din,
    output logic                  bus_done,
    output gba_io_pkg::io_word_u  bus_dout,
    output gba_io_pkg::io_req_t   timer_req,
    output gba_io_pkg::io_req_t   key_req,
    output gba_io_pkg::io_req_t   intr_req,
    input  gba_io_pkg::io_word_u  timer_rdata,
    input  gba_io_pkg::io_word_u  key_rdata,
    input  gba_io_pkg::io_word_u  intr_rdata
);

    function automatic gba_io_pkg::io_be_t calc_be(gba_io_pkg::io_acc_e acc,
                                                   logic [1:0] lo);
        gba_io_pkg::io_be_t be;
        case (acc)
            gba_io_pkg::ACC_BYTE: be = 4'b0001 << lo;
            gba_io_pkg::ACC_HALF: be = lo[1] ? 4'b1100 : 4'b0011;
            gba_io_pkg::ACC_WORD: be = 4'b1111;
            default:              be = 4'b0000;
        endcase
        return be;
    endfunction

    logic                 timer_hit;
    logic                 key_hit;
    logic                 intr_hit;
    gba_io_pkg::io_req_t  req;
    gba_io_pkg::io_word_u rd_sel;

    //////////////////////////////
    // decode
    //////////////////////////////

    assign timer_hit = bus_adr[27:4] == gba_io_pkg::TIMER_BASE[27:4];
    assign key_hit   = bus_adr[27:2] == gba_io_pkg::KEY_BASE[27:2];
    assign intr_hit  = bus_adr[27:4] == gba_io_pkg::INTR_BASE[27:4];

    // common request, valid gated per region below
    always_comb begin
        req       = '0;
        req.we    = ~bus_rnw;
        req.idx   = bus_adr[3:2];
        req.be    = calc_be(bus_acc, bus_adr[1:0]);
        req.wdata = bus_din;
    end

    always_comb begin
        timer_req       = req;
        timer_req.valid = bus_ena & timer_hit;
        key_req         = req;
        key_req.valid   = bus_ena & key_hit;
        intr_req        = req;
        intr_req.valid  = bus_ena & intr_hit;
    end

    //////////////////////////////
    // read return
    //////////////////////////////

    always_comb begin
        if (timer_hit)
            rd_sel = timer_rdata;
        else if (key_hit)
            rd_sel = key_rdata;
        else if (intr_hit)
            rd_sel = intr_rdata;
        else
            rd_sel = '0;   // unmapped
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            bus_done <= 1'b0;
            bus_dout <= '0;
        end else begin
            bus_done <= bus_ena;
            if (bus_ena)
                bus_dout <= rd_sel;   // whole word, enables ignored on read
        end
    end

endmodule

// File: src/gba_interrupts.sv
// interrupt controller: IE/IF at word 0, IME at word 2, halt request at word 3
// words 1 and 3 read as 0; halt is write-only
// a set from a source wins over a write-1 clear in the same cycle
module gba_interrupts (
    input  logic                  clk16,
    input  logic                  resetn,
    input  gba_io_pkg::io_req_t   req,
    output gba_io_pkg::io_word_u  rdata,
    input  gba_io_pkg::irq_src_t  irq_ext,
    input  logic [3:0]            timer_irq,
    input  logic                  key_irq,
    output logic                  irq,
    output logic                  halt
);

    logic [13:0]          ie_q;
    logic [13:0]          if_q;
    logic                 ime_q;
    logic                 wr;
    logic [13:0]          if_clr;
    logic                 pending;
    gba_io_pkg::io_half_t ie_new;
    gba_io_pkg::irq_src_t src;

    assign wr = req.valid & req.we;

    // local sources replace the external timer and keypad bits
    always_comb begin
        src        = irq_ext;
        src.timer  = timer_irq;
        src.keypad = key_irq;
    end

    always_comb begin
        if_clr = '0;
        if (wr && req.idx == 2'd0) begin
            if (req.be[2])
                if_clr[7:0] = req.wdata.raw[23:16];
            if (req.be[3])
                if_clr[13:8] = req.wdata.raw[29:24];
        end
    end

    assign ie_new  = gba_io_pkg::merge_half({2'b00, ie_q}, req.wdata.halves.lo, req.be[1:0]);
    assign pending = |(ie_q & if_q);

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            ie_q  <= '0;
            if_q  <= '0;
            ime_q <= 1'b0;
            halt  <= 1'b0;
            irq   <= 1'b0;
        end else begin
            if (wr && req.idx == 2'd0)
                ie_q <= ie_new[13:0];
            if_q <= (if_q & ~if_clr) | src;
            if (wr && req.idx == 2'd2 && req.be[0])
                ime_q <= req.wdata.raw[0];

            if (pending)
                halt <= 1'b0;   // any enabled flag wakes, IME not involved
            else if (wr && req.idx == 2'd3 && req.be[1])
                halt <= 1'b1;

            irq <= ime_q & pending;
        end
    end

    always_comb begin
        rdata = '0;
        case (req.idx)
            2'd0:    rdata.raw = {2'b00, if_q, 2'b00, ie_q};
            2'd2:    rdata.raw = {31'd0, ime_q};
            default: rdata.raw = '0;
        endcase
    end

endmodule

// File: src/gba_joypad.sv
// keypad: KEYINPUT (lo, active low, read-only) and KEYCNT (hi)
// key_irq is a registered level, high while the KEYCNT condition holds
module gba_joypad (
    input  logic                 clk16,
    input  logic                 resetn,
    input  gba_io_pkg::io_req_t  req,
    output gba_io_pkg::io_word_u rdata,
    input  gba_io_pkg::keys_t    keys,
    output logic                 key_irq
);

    logic [9:0] mask_q;
    logic       en_q;
    logic       mode_q;   // 1: all masked keys, 0: any
    logic [9:0] hit;
    logic       cond;

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            mask_q  <= '0;
            en_q    <= 1'b0;
            mode_q  <= 1'b0;
            key_irq <= 1'b0;
        end else begin
            if (req.valid && req.we && req.be[2])
                mask_q[7:0] <= req.wdata.raw[23:16];
            if (req.valid && req.we && req.be[3]) begin
                mask_q[9:8] <= req.wdata.raw[25:24];
                en_q        <= req.wdata.raw[30];
                mode_q      <= req.wdata.raw[31];
            end
            key_irq <= cond;
        end
    end

    assign hit  = keys & mask_q;
    assign cond = en_q & (mode_q ? (hit == mask_q) : |hit);

    assign rdata.halves.lo = {6'd0, ~keys};
    assign rdata.halves.hi = {mode_q, en_q, 4'd0, mask_q};

endmodule

// File: src/gba_io_top.sv
// memory-mapped I/O block: timers, keypad and interrupt controller
// bus master must wait for done before the next ena
// irq_ext timer and keypad fields are ignored
module gba_io_top (
    input  logic                 clk16,
    input  logic                 resetn,
    input  logic                 bus_ena,
    input  logic                 bus_rnw,
    input  gba_io_pkg::io_adr_t  bus_adr,
    input  gba_io_pkg::io_acc_e  bus_acc,
    input  gba_io_pkg::io_word_u bus_din,
    output logic                 bus_done,
    output gba_io_pkg::io_word_u bus_dout,
    input  gba_io_pkg::keys_t    keys,
    input  gba_io_pkg::irq_src_t irq_ext,
    output logic                 irq,
    output logic                 halt
);

    gba_io_pkg::io_req_t  timer_req;
    gba_io_pkg::io_req_t  key_req;
    gba_io_pkg::io_req_t  intr_req;
    gba_io_pkg::io_word_u timer_rdata;
    gba_io_pkg::io_word_u key_rdata;
    gba_io_pkg::io_word_u intr_rdata;
    logic [3:0]           timer_irq;
    logic                 key_irq;

    gba_io_bus u_bus (
        .clk16       (clk16),
        .resetn      (resetn),
        .bus_ena     (bus_ena),
        .bus_rnw     (bus_rnw),
        .bus_adr     (bus_adr),
        .bus_acc     (bus_acc),
        .bus_din     (bus_din),
        .bus_done    (bus_done),
        .bus_dout    (bus_dout),
        .timer_req   (timer_req),
        .key_req     (key_req),
        .intr_req    (intr_req),
        .timer_rdata (timer_rdata),
        .key_rdata   (key_rdata),
        .intr_rdata  (intr_rdata)
    );

    gba_timers u_timers (
        .clk16     (clk16),
        .resetn    (resetn),
        .req       (timer_req),
        .rdata     (timer_rdata),
        .timer_irq (timer_irq)
    );

    gba_joypad u_joypad (
        .clk16   (clk16),
        .resetn  (resetn),
        .req     (key_req),
        .rdata   (key_rdata),
        .keys    (keys),
        .key_irq (key_irq)
    );

    gba_interrupts u_intr (
        .clk16     (clk16),
        .resetn    (resetn),
        .req       (intr_req),
        .rdata     (intr_rdata),
        .irq_ext   (irq_ext),
        .timer_irq (timer_irq),
        .key_irq   (key_irq),
        .irq       (irq),
        .halt      (halt)
    );

endmodule

// File: verification/gba_io_sva.sv
// bus handshake and irq gating assertions, bound into gba_io_top
// ime is picked up from the interrupt block through the bind connection
module gba_io_sva (
    input logic clk16,
    input logic resetn,
    input logic bus_ena,
    input logic bus_done,
    input logic irq,
    input logic ime
);

    int unsigned fail_cnt = 0;

    a_done_after_ena: assert property (@(posedge clk16) disable iff (!resetn)
        bus_ena |=> bus_done)
    else begin
        $error("bus_done missing one cycle after bus_ena");
        fail_cnt++;
    end

    a_done_needs_ena: assert property (@(posedge clk16) disable iff (!resetn)
        bus_done |-> $past(bus_ena))
    else begin
        $error("bus_done without bus_ena in the cycle before");
        fail_cnt++;
    end

    // irq is registered from ime
    a_irq_needs_ime: assert property (@(posedge clk16) disable iff (!resetn)
        !ime |=> !irq)
    else begin
        $error("irq high although IME was 0");
        fail_cnt++;
    end

endmodule

bind gba_io_top gba_io_sva u_sva (
    .clk16    (clk16),
    .resetn   (resetn),
    .bus_ena  (bus_ena),
    .bus_done (bus_done),
    .irq      (irq),
    .ime      (u_intr.ime_q)
);

// File: verification/gba_io_tb.sv
// testbench for the I/O block: random register traffic against a register model
// stimulus changes on the falling edge, bus_dout is taken in the done cycle
// timer counts are modelled only while the timers are stopped
module gba_io_tb;

    localparam int N_REG = 200;
    localparam int N_KEY = 40;
    localparam int N_IRQ = 40;
    localparam int N_TMR = 30;
    // upper bound on bus accesses over the whole run
    localparam int TOTAL_TXN = 2 * N_REG + 5 * N_KEY + 6 * N_IRQ + N_TMR + 120;
    localparam logic [13:0] EXT_SRC = 14'h2F87;   // sources that come from outside

    logic                 clk16;
    logic                 resetn;
    logic                 bus_ena;
    logic                 bus_rnw;
    gba_io_pkg::io_adr_t  bus_adr;
    gba_io_pkg::io_acc_e  bus_acc;
    gba_io_pkg::io_word_u bus_din;
    logic                 bus_done;
    gba_io_pkg::io_word_u bus_dout;
    gba_io_pkg::keys_t    keys;
    gba_io_pkg::irq_src_t irq_ext;
    logic                 irq;
    logic                 halt;

    integer      seed = 32'h77bc_0fa0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    longint      cyc = 0;        // rising edges since time 0
    longint      strobe_cyc;
    logic [31:0] map_m [int unsigned];
    logic [13:0] if_m = '0;

    gba_io_top dut (
        .clk16    (clk16),
        .resetn   (resetn),
        .bus_ena  (bus_ena),
        .bus_rnw  (bus_rnw),
        .bus_adr  (bus_adr),
        .bus_acc  (bus_acc),
        .bus_din  (bus_din),
        .bus_done (bus_done),
        .bus_dout (bus_dout),
        .keys     (keys),
        .irq_ext  (irq_ext),
        .irq      (irq),
        .halt     (halt)
    );

    initial begin
        clk16 = 1'b0;
        forever #2 clk16 = ~clk16;
    end

    always @(posedge clk16)
        cyc <= cyc + 1;

    //////////////////////////////
    // register model
    //////////////////////////////

    function automatic gba_io_pkg::io_be_t lanes(gba_io_pkg::io_acc_e acc, logic [1:0] lo);
        case (acc)
            gba_io_pkg::ACC_BYTE: return gba_io_pkg::io_be_t'(1 << lo);
            gba_io_pkg::ACC_HALF: return lo[1] ? 4'hC : 4'h3;
            gba_io_pkg::ACC_WORD: return 4'hF;
            default:              return 4'h0;
        endcase
    endfunction

    // writable bits per word
    function automatic logic [31:0] write_mask(int unsigned wa);
        if (wa >= gba_io_pkg::TIMER_BASE && wa <= gba_io_pkg::TIMER_BASE + 12)
            return 32'h00C7_0000;   // control fields only, count is not a plain register
        if (wa == gba_io_pkg::KEY_BASE)
            return 32'hC3FF_0000;
        if (wa == gba_io_pkg::INTR_BASE)
            return 32'h0000_3FFF;
        if (wa == gba_io_pkg::INTR_BASE + 8)
            return 32'h0000_0001;
        return '0;
    endfunction

    function automatic logic [31:0] map_get(int unsigned wa);
        return map_m.exists(wa) ? map_m[wa] : '0;
    endfunction

    function automatic void model_write(gba_io_pkg::io_adr_t adr, gba_io_pkg::io_acc_e acc,
                                        logic [31:0] data);
        int unsigned        wa;
        gba_io_pkg::io_be_t be;
        logic [31:0]        lm;
        logic [31:0]        wm;
        wa = {adr[27:2], 2'b00};
        be = lanes(acc, adr[1:0]);
        lm = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        wm = write_mask(wa) & lm;
        map_m[wa] = (map_get(wa) & ~wm) | (data & wm);
        if (wa == gba_io_pkg::INTR_BASE)
            if_m = if_m & ~(data[29:16] & lm[29:16]);   // write 1 clears
    endfunction

    function automatic gba_io_pkg::io_word_u expect_read(int unsigned wa);
        gba_io_pkg::io_word_u w;
        w.raw = map_get(wa);
        if (wa == gba_io_pkg::KEY_BASE)
            w.halves.lo = {6'd0, ~keys};
        if (wa == gba_io_pkg::INTR_BASE)
            w.halves.hi = {2'b00, if_m};
        return w;
    endfunction

    function automatic logic irq_expected();
        return map_get(gba_io_pkg::INTR_BASE + 8) & |(map_get(gba_io_pkg::INTR_BASE) & if_m);
    endfunction

    function automatic logic key_cond(logic [9:0] kv);
        logic [15:0] kc;
        logic [9:0]  mask;
        kc   = map_get(gba_io_pkg::KEY_BASE) >> 16;
        mask = kc[9:0];
        if (!kc[14])
            return 1'b0;
        return kc[15] ? ((kv & mask) == mask) : ((kv & mask) != 0);
    endfunction

    //////////////////////////////
    // checks and bus access
    //////////////////////////////

    task automatic check_word(string sig, gba_io_pkg::io_word_u got,
                              gba_io_pkg::io_word_u exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, sig, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic check_bit(string sig, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic bus_access(input logic rnw, input gba_io_pkg::io_adr_t adr,
                              input gba_io_pkg::io_acc_e acc, input logic [31:0] data,
                              output gba_io_pkg::io_word_u dout);
        int waited;
        @(negedge clk16);
        bus_ena     = 1'b1;
        bus_rnw     = rnw;
        bus_adr     = adr;
        bus_acc     = acc;
        bus_din.raw = data;
        strobe_cyc  = cyc;
        @(negedge clk16);
        bus_ena = 1'b0;
        waited  = 0;
        while (!bus_done && waited < 8) begin
            @(negedge clk16);
            waited++;
        end
        if (!bus_done)
            report_failure($sformatf("access to address %h never returned done", adr));
        dout = bus_dout;
    endtask

    task automatic write_reg(gba_io_pkg::io_adr_t adr, gba_io_pkg::io_acc_e acc,
                             logic [31:0] data);
        gba_io_pkg::io_word_u unused;
        bus_access(1'b0, adr, acc, data, unused);
        model_write(adr, acc, data);
    endtask

    task automatic read_check(gba_io_pkg::io_adr_t wa);
        gba_io_pkg::io_word_u got;
        bus_access(1'b1, wa, gba_io_pkg::ACC_WORD, '0, got);
        check_word("bus_dout", got, expect_read(wa));
    endtask

    task automatic pulse_irq(logic [13:0] bits);
        @(negedge clk16);
        irq_ext = bits;
        @(negedge clk16);
        irq_ext = '0;
    endtask

    task automatic test_end(string name, int err0);
        tests++;
        $display("test %-10s %s", name, (errors == err0) ? "ok" : "FAILED");
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_regs();
        int                  err0;
        int                  sel;
        logic [31:0]         r;
        logic [31:0]         data;
        logic [1:0]          lo;
        gba_io_pkg::io_adr_t wa;
        gba_io_pkg::io_acc_e acc;
        int unsigned         spare [4] = '{'h120, 'h134, 'h204, 'h3FC};
        err0 = errors;
        for (int i = 0; i < N_REG; i++) begin
            sel = $random(seed) & 7;
            case (sel)
                0, 1, 2, 3: wa = gba_io_pkg::TIMER_BASE + 4 * sel;
                4:          wa = gba_io_pkg::KEY_BASE;
                5:          wa = gba_io_pkg::INTR_BASE;
                6:          wa = gba_io_pkg::INTR_BASE + 8;
                default:    wa = spare[$random(seed) & 3];   // unmapped or reserved
            endcase
            acc  = gba_io_pkg::io_acc_e'($random(seed) & 3);
            r    = $random(seed);
            lo   = (acc == gba_io_pkg::ACC_BYTE) ? r[1:0] :
                   (acc == gba_io_pkg::ACC_HALF) ? {r[1], 1'b0} : 2'b00;
            data = $random(seed);
            if (sel < 4)
                data[23] = 1'b0;   // timers stay stopped
            if (sel == 4)
                data[30] = 1'b0;   // key interrupt stays off
            write_reg(wa | lo, acc, data);
            read_check(wa);
        end
        test_end("regs", err0);
    endtask

    task automatic test_keys();
        int          err0;
        logic [15:0] kc;
        logic [9:0]  kv;
        err0 = errors;
        for (int i = 0; i < N_KEY; i++) begin
            if (i % 5 == 0) begin
                kc        = $random(seed);
                kc[14]    = 1'b1;
                kc[13:10] = '0;
                write_reg(gba_io_pkg::KEY_BASE + 2, gba_io_pkg::ACC_HALF, {kc, 16'h0});
            end
            kv = $random(seed);
            @(negedge clk16);
            keys = kv;
            repeat (2) @(negedge clk16);
            read_check(gba_io_pkg::KEY_BASE);
            // clear the key flag, it comes back while the condition holds
            write_reg(gba_io_pkg::INTR_BASE + 3, gba_io_pkg::ACC_BYTE, 32'h1000_0000);
            if (key_cond(kv))
                if_m[12] = 1'b1;
            read_check(gba_io_pkg::INTR_BASE);
        end
        write_reg(gba_io_pkg::KEY_BASE + 2, gba_io_pkg::ACC_HALF, '0);
        @(negedge clk16);
        keys = '0;
        repeat (2) @(negedge clk16);
        write_reg(gba_io_pkg::INTR_BASE + 3, gba_io_pkg::ACC_BYTE, 32'h1000_0000);
        read_check(gba_io_pkg::INTR_BASE);
        test_end("keys", err0);
    endtask

    task automatic test_irq();
        int          err0;
        logic [31:0] r;
        logic [13:0] src;
        err0 = errors;
        for (int i = 0; i < N_IRQ; i++) begin
            r = $random(seed);
            write_reg(gba_io_pkg::INTR_BASE, gba_io_pkg::ACC_HALF, {16'h0, r[15:0]});
            write_reg(gba_io_pkg::INTR_BASE + 8, gba_io_pkg::ACC_BYTE, {31'd0, r[16]});
            src = $random(seed);
            pulse_irq(src);
            if_m = if_m | (src & EXT_SRC);   // timer and key bits are ignored
            repeat (2) @(negedge clk16);
            check_bit("irq", irq, irq_expected());
            read_check(gba_io_pkg::INTR_BASE);
            r = $random(seed);
            write_reg(gba_io_pkg::INTR_BASE + 2, gba_io_pkg::ACC_HALF, {r[15:0], 16'h0});
            repeat (2) @(negedge clk16);
            check_bit("irq", irq, irq_expected());
            read_check(gba_io_pkg::INTR_BASE);
        end
        test_end("irq", err0);
    endtask

    task automatic test_timers();
        int                   err0;
        int                   wraps;
        logic                 seen;
        logic [15:0]          prev;
        longint               prev_cyc;
        longint               t0;
        gba_io_pkg::io_word_u got;
        gba_io_pkg::io_word_u exp;
        err0 = errors;
        write_reg(gba_io_pkg::TIMER_BASE, gba_io_pkg::ACC_HALF, 32'h0000_FFFF);
        write_reg(gba_io_pkg::TIMER_BASE + 4, gba_io_pkg::ACC_HALF, 32'h0000_FFF0);
        write_reg(gba_io_pkg::TIMER_BASE + 6, gba_io_pkg::ACC_HALF, 32'h00C4_0000);
        bus_access(1'b1, gba_io_pkg::TIMER_BASE + 4, gba_io_pkg::ACC_WORD, '0, got);
        exp.raw = 32'h00C4_FFF0;   // started, no cascade input yet
        check_word("bus_dout", got, exp);
        write_reg(gba_io_pkg::TIMER_BASE + 2, gba_io_pkg::ACC_HALF, 32'h0080_0000);
        bus_access(1'b1, gba_io_pkg::TIMER_BASE + 4, gba_io_pkg::ACC_WORD, '0, got);
        prev     = got.halves.lo;
        prev_cyc = strobe_cyc;
        wraps    = 0;
        checks++;
        if (prev < 16'hFFF0)
            report_failure($sformatf("timer 1 count %h below its reload value", prev));
        // timer 0 overflows every cycle, so timer 1 steps once per cycle
        for (int i = 0; i < N_TMR; i++) begin
            repeat ($random(seed) & 7) @(negedge clk16);
            bus_access(1'b1, gba_io_pkg::TIMER_BASE + 4, gba_io_pkg::ACC_WORD, '0, got);
            exp.raw = {16'h00C4,
                       16'hFFF0 + 16'((prev - 16'hFFF0 + (strobe_cyc - prev_cyc)) % 16)};
            check_word("bus_dout", got, exp);
            if (got.halves.lo < prev)
                wraps++;
            prev     = got.halves.lo;
            prev_cyc = strobe_cyc;
        end
        checks++;
        if (wraps == 0)
            report_failure("timer 1 never wrapped back to its reload value");
        write_reg(gba_io_pkg::INTR_BASE + 2, gba_io_pkg::ACC_BYTE, 32'h0010_0000);
        t0   = cyc;
        seen = 1'b0;
        while (!seen && cyc - t0 < 64) begin
            bus_access(1'b1, gba_io_pkg::INTR_BASE, gba_io_pkg::ACC_WORD, '0, got);
            seen = got.raw[20];
        end
        checks++;
        if (!seen)
            report_failure("timer 1 flag not set in IF within 64 cycles");
        write_reg(gba_io_pkg::TIMER_BASE + 2, gba_io_pkg::ACC_HALF, '0);
        bus_access(1'b1, gba_io_pkg::TIMER_BASE + 4, gba_io_pkg::ACC_WORD, '0, exp);
        repeat (10) @(negedge clk16);
        bus_access(1'b1, gba_io_pkg::TIMER_BASE + 4, gba_io_pkg::ACC_WORD, '0, got);
        check_word("bus_dout", got, exp);   // no cascade input, no change
        write_reg(gba_io_pkg::TIMER_BASE + 6, gba_io_pkg::ACC_HALF, '0);
        write_reg(gba_io_pkg::INTR_BASE + 2, gba_io_pkg::ACC_HALF, 32'h3FFF_0000);
        read_check(gba_io_pkg::INTR_BASE);
        test_end("timers", err0);
    endtask

    task automatic test_halt();
        int err0;
        int b;
        err0 = errors;
        write_reg(gba_io_pkg::INTR_BASE + 2, gba_io_pkg::ACC_HALF, 32'h3FFF_0000);
        b = $random(seed) & 15;
        while (b > 13 || !EXT_SRC[b])
            b = $random(seed) & 15;
        write_reg(gba_io_pkg::INTR_BASE, gba_io_pkg::ACC_HALF, 32'(1 << b));
        for (int m = 0; m < 2; m++) begin
            write_reg(gba_io_pkg::INTR_BASE + 8, gba_io_pkg::ACC_BYTE, 32'(m));
            write_reg(gba_io_pkg::INTR_BASE + 'hD, gba_io_pkg::ACC_BYTE, 32'h0000_0100);
            check_bit("halt", halt, 1'b1);
            repeat (4) @(negedge clk16);
            check_bit("halt", halt, 1'b1);   // nothing pending yet
            pulse_irq(14'(1 << b));
            if_m[b] = 1'b1;
            repeat (2) @(negedge clk16);
            check_bit("halt", halt, 1'b0);
            check_bit("irq", irq, m[0]);
            write_reg(gba_io_pkg::INTR_BASE + 2, gba_io_pkg::ACC_HALF, 32'(1 << (b + 16)));
        end
        test_end("halt", err0);
    endtask

    initial begin
        repeat (TOTAL_TXN * 40) @(posedge clk16);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        resetn      = 1'b0;
        bus_ena     = 1'b0;
        bus_rnw     = 1'b1;
        bus_adr     = '0;
        bus_acc     = gba_io_pkg::ACC_WORD;
        bus_din.raw = '0;
        keys        = '0;
        irq_ext     = '0;
        repeat (4) @(negedge clk16);
        resetn = 1'b1;
        check_bit("bus_done", bus_done, 1'b0);
        check_bit("irq", irq, 1'b0);
        check_bit("halt", halt, 1'b0);
        test_regs();
        test_keys();
        test_irq();
        test_timers();
        test_halt();
        repeat (2) @(negedge clk16);
        errors += dut.u_sva.fail_cnt;   // failed bound assertions
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: compile.f
src/gba_io_pkg.sv
src/gba_timer_channel.sv
src/gba_timers.sv
src/gba_io_bus.sv
src/gba_interrupts.sv
src/gba_joypad.sv
src/gba_io_top.sv
verification/gba_io_sva.sv
verification/gba_io_tb.sv

// File: Bender.yml
package:
  name: gba_io

sources:
  - src/gba_io_pkg.sv
  - src/gba_timer_channel.sv
  - src/gba_timers.sv
  - src/gba_io_bus.sv
  - src/gba_interrupts.sv
  - src/gba_joypad.sv
  - src/gba_io_top.sv
  - target: test
    files:
      - verification/gba_io_sva.sv
      - verification/gba_io_tb.sv
